/* hw/cop_macros.svh */
`ifndef COP_MACROS_SVH
`define COP_MACROS_SVH

// Register file and scratch memory sizes
`define COP_NUM_XCR       16
`define COP_MEM_WORDS     256

// Bus widths
`define COP_ADDR_W        32
`define COP_DATA_W        32

// Major opcode of every coprocessor instruction
`define COP_OPCODE_CUSTOM 7'b0001011

`endif

/* hw/cop_isa_pkg.sv */
`include "cop_macros.svh"

package cop_isa_pkg;

    localparam int XCR_IDX_W = $clog2(`COP_NUM_XCR);

    typedef enum logic [3:0] {
        PADD    = 4'd0,
        PSUB    = 4'd1,
        PSLL_I  = 4'd2,
        PSRL_I  = 4'd3,
        GPR2XCR = 4'd4,
        XCR2GPR = 4'd5,
        LD_W    = 4'd6,
        ST_W    = 4'd7  // 8 to 15 are illegal
    } cop_op_e;

    typedef enum logic [2:0] {
        CLASS_PACKED_ARITH = 3'd0,
        CLASS_MOVE         = 3'd1,
        CLASS_LOADSTORE    = 3'd2,
        CLASS_NONE         = 3'd7
    } cop_class_e;

    typedef enum logic [2:0] {
        PW_32 = 3'b000,
        PW_16 = 3'b001,
        PW_8  = 3'b010
    } cop_pw_e;

    typedef struct packed {
        logic                   exception;
        cop_class_e             iclass;
        cop_op_e                op;
        cop_pw_e                pw;
        logic [XCR_IDX_W-1:0]   crd;
        logic [XCR_IDX_W-1:0]   crs1;
        logic [XCR_IDX_W-1:0]   crs2;
        logic [4:0]             rd;     // GPR destination
        logic [`COP_DATA_W-1:0] imm;    // Zero-extended
    } cop_decoded_t;

endpackage

/* hw/cop_bus_pkg.sv */
`include "cop_macros.svh"

package cop_bus_pkg;

    // AXI4-Lite master to slave
    typedef struct packed {
        logic                     aw_valid;
        logic [`COP_ADDR_W-1:0]   aw_addr;
        logic                     w_valid;
        logic [`COP_DATA_W-1:0]   w_data;
        logic [`COP_DATA_W/8-1:0] w_strb;
        logic                     b_ready;
        logic                     ar_valid;
        logic [`COP_ADDR_W-1:0]   ar_addr;
        logic                     r_ready;
    } axil_req_t;

    // AXI4-Lite slave to master
    typedef struct packed {
        logic                   aw_ready;
        logic                   w_ready;
        logic                   b_valid;
        logic [1:0]             b_resp;
        logic                   ar_ready;
        logic                   r_valid;
        logic [`COP_DATA_W-1:0] r_data;
        logic [1:0]             r_resp;
    } axil_rsp_t;

    typedef enum logic [1:0] {ARB_IDLE, ARB_HOST, ARB_LSU} arb_state_e;

endpackage

/* hw/cop_idecode.sv */
`timescale 1ns/10ps
`include "cop_macros.svh"

module cop_idecode
    import cop_isa_pkg::*;
(
    input  logic [31:0]  encoded_i,  // Raw instruction word
    output cop_decoded_t decoded_o
);

    logic [3:0] op_raw;
    logic [2:0] pw_raw;
    logic       bad_major;
    logic       bad_op;
    logic       bad_pack_width;
    cop_class_e iclass;

    assign op_raw    = encoded_i[31:28];
    assign pw_raw    = encoded_i[21:19];
    assign bad_major = encoded_i[6:0] != `COP_OPCODE_CUSTOM;
    assign bad_op    = op_raw[3];  // Opcodes 8 and up are unused

    // Class follows directly from the op field
    always_comb begin
        case (op_raw)
            4'd0, 4'd1, 4'd2, 4'd3: iclass = CLASS_PACKED_ARITH;
            4'd4, 4'd5:             iclass = CLASS_MOVE;
            4'd6, 4'd7:             iclass = CLASS_LOADSTORE;
            default:                iclass = CLASS_NONE;
        endcase
    end

    // Only 000, 001 and 010 are legal widths
    assign bad_pack_width =
        (pw_raw[2] || (&pw_raw[1:0])) &&
        iclass == CLASS_PACKED_ARITH;

    always_comb begin
        decoded_o.exception = bad_major || bad_op || bad_pack_width;
        decoded_o.iclass    = iclass;
        decoded_o.op        = cop_op_e'(op_raw);
        decoded_o.pw        = cop_pw_e'(pw_raw);
        decoded_o.crd       = encoded_i[10:7];
        decoded_o.crs1      = encoded_i[14:11];
        decoded_o.crs2      = encoded_i[18:15];
        decoded_o.rd        = encoded_i[11:7];   // Overlaps crd by design
        decoded_o.imm       = {26'd0, encoded_i[27:22]};
    end

endmodule

/* hw/cop_palu.sv */
`timescale 1ns/10ps

module cop_palu
    import cop_isa_pkg::*;
(
    input  cop_op_e     op_i,
    input  cop_pw_e     pw_i,
    input  logic [31:0] a_i,
    input  logic [31:0] b_i,
    input  logic [5:0]  shamt_i,
    output logic [31:0] result_o
);

    logic [3:0]  lane_start;  // Byte that begins a lane
    logic [4:0]  sh;
    logic [31:0] lmask, rmask, sum, b_x;
    logic        sub;

    assign sub = op_i == PSUB;
    assign b_x = sub ? ~b_i : b_i;  // a + ~b + 1 per lane

    always_comb begin
        case (pw_i)
            PW_16: begin
                lane_start = 4'b0101;
                sh         = {1'b0, shamt_i[3:0]};
                lmask      = {2{16'hffff << sh}};
                rmask      = {2{16'hffff >> sh}};
            end
            PW_8: begin
                lane_start = 4'b1111;
                sh         = {2'b00, shamt_i[2:0]};
                lmask      = {4{8'hff << sh}};
                rmask      = {4{8'hff >> sh}};
            end
            default: begin
                lane_start = 4'b0001;
                sh         = shamt_i[4:0];
                lmask      = 32'hffff_ffff << sh;
                rmask      = 32'hffff_ffff >> sh;
            end
        endcase
    end

    // Byte-wise ripple, chain cut at every lane start
    always_comb begin
        logic carry;
        logic cin;
        carry = 1'b0;
        for (int i = 0; i < 4; i++) begin
            cin = lane_start[i] ? sub : carry;
            {carry, sum[i*8 +: 8]} = {1'b0, a_i[i*8 +: 8]} + {1'b0, b_x[i*8 +: 8]} + {8'd0, cin};
        end
    end

    always_comb begin
        case (op_i)
            PADD, PSUB: result_o = sum;
            PSLL_I:     result_o = (a_i << sh) & lmask;  // Drop bits from lower lanes
            PSRL_I:     result_o = (a_i >> sh) & rmask;
            default:    result_o = '0;
        endcase
    end

endmodule

/* hw/cop_lsu.sv */
`timescale 1ns/10ps
`include "cop_macros.svh"

module cop_lsu
    import cop_bus_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   start_i,
    input  logic                   store_i,
    input  logic [`COP_ADDR_W-1:0] addr_i,
    input  logic [`COP_DATA_W-1:0] wdata_i,
    output logic                   done_o,
    output logic [`COP_DATA_W-1:0] rdata_o,
    output axil_req_t              req_o,
    input  axil_rsp_t              rsp_i
);

    typedef enum logic [1:0] {LSU_IDLE, LSU_ADDR, LSU_RESP} lsu_state_e;

    lsu_state_e             state_q;
    logic                   store_q;
    logic [`COP_ADDR_W-1:0] addr_q;
    logic [`COP_DATA_W-1:0] wdata_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= LSU_IDLE;
            store_q <= 1'b0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                LSU_IDLE: if (start_i) begin
                    state_q <= LSU_ADDR;
                    store_q <= store_i;
                end
                LSU_ADDR: if (store_q ? (rsp_i.aw_ready && rsp_i.w_ready) : rsp_i.ar_ready)
                    state_q <= LSU_RESP;
                LSU_RESP: if (store_q ? rsp_i.b_valid : rsp_i.r_valid) begin
                    state_q <= LSU_IDLE;
                    done_o  <= 1'b1;  // Cycle after the response handshake
                end
                default: state_q <= LSU_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == LSU_IDLE && start_i) begin
            addr_q  <= addr_i;
            wdata_q <= wdata_i;
        end
        if (state_q == LSU_RESP && !store_q && rsp_i.r_valid) rdata_o <= rsp_i.r_data;
    end

    always_comb begin
        req_o          = '0;
        req_o.aw_valid = state_q == LSU_ADDR && store_q;
        req_o.w_valid  = state_q == LSU_ADDR && store_q;  // Issued with aw
        req_o.aw_addr  = addr_q;
        req_o.w_data   = wdata_q;
        req_o.w_strb   = '1;
        req_o.b_ready  = state_q == LSU_RESP && store_q;
        req_o.ar_valid = state_q == LSU_ADDR && !store_q;
        req_o.ar_addr  = addr_q;
        req_o.r_ready  = state_q == LSU_RESP && !store_q;
    end

endmodule

/* hw/cop_mem_arbiter.sv */
`timescale 1ns/10ps

module cop_mem_arbiter
    import cop_bus_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  axil_req_t host_req_i,
    output axil_rsp_t host_rsp_o,
    input  axil_req_t lsu_req_i,
    output axil_rsp_t lsu_rsp_o,
    output axil_req_t mem_req_o,
    input  axil_rsp_t mem_rsp_i
);

    arb_state_e state_q;
    logic       last_lsu_q;  // LSU held the last grant
    logic       host_pend, lsu_pend, txn_end;

    assign host_pend = host_req_i.aw_valid || host_req_i.ar_valid;
    assign lsu_pend  = lsu_req_i.aw_valid || lsu_req_i.ar_valid;
    assign txn_end   = (mem_req_o.b_ready && mem_rsp_i.b_valid) ||
                       (mem_req_o.r_ready && mem_rsp_i.r_valid);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= ARB_IDLE;
            last_lsu_q <= 1'b0;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    // Round robin when both ask
                    if (host_pend && (!lsu_pend || last_lsu_q)) begin
                        state_q    <= ARB_HOST;
                        last_lsu_q <= 1'b0;
                    end else if (lsu_pend) begin
                        state_q    <= ARB_LSU;
                        last_lsu_q <= 1'b1;
                    end
                end
                ARB_HOST, ARB_LSU: if (txn_end) state_q <= ARB_IDLE;
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

    always_comb begin
        mem_req_o  = '0;
        host_rsp_o = '0;
        lsu_rsp_o  = '0;
        case (state_q)
            ARB_HOST: begin
                mem_req_o  = host_req_i;
                host_rsp_o = mem_rsp_i;
            end
            ARB_LSU: begin
                mem_req_o = lsu_req_i;
                lsu_rsp_o = mem_rsp_i;
            end
            default: ;
        endcase
    end

endmodule

/* hw/cop_scratch_mem.sv */
`timescale 1ns/10ps
`include "cop_macros.svh"

module cop_scratch_mem
    import cop_bus_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  axil_req_t req_i,
    output axil_rsp_t rsp_o
);

    localparam int IDX_W = $clog2(`COP_MEM_WORDS);

    logic [`COP_DATA_W-1:0] mem_q [`COP_MEM_WORDS];
    logic [`COP_DATA_W-1:0] r_data_q;
    logic                   wr_rdy_q, rd_rdy_q, b_valid_q, r_valid_q;
    logic                   wr_fire, rd_fire;
    logic [IDX_W-1:0]       wr_idx, rd_idx;

    // Upper address bits ignored, so accesses wrap
    assign wr_idx  = req_i.aw_addr[IDX_W+1:2];
    assign rd_idx  = req_i.ar_addr[IDX_W+1:2];
    assign wr_fire = wr_rdy_q && req_i.aw_valid && req_i.w_valid;
    assign rd_fire = rd_rdy_q && req_i.ar_valid;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_rdy_q  <= 1'b0;
            rd_rdy_q  <= 1'b0;
            b_valid_q <= 1'b0;
            r_valid_q <= 1'b0;
        end else begin
            // Ready one cycle after valid, for a single beat
            wr_rdy_q <= req_i.aw_valid && req_i.w_valid && !wr_rdy_q && !b_valid_q;
            rd_rdy_q <= req_i.ar_valid && !rd_rdy_q && !r_valid_q;
            if (wr_fire) b_valid_q <= 1'b1;
            else if (req_i.b_ready) b_valid_q <= 1'b0;
            if (rd_fire) r_valid_q <= 1'b1;
            else if (req_i.r_ready) r_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_fire) begin
            for (int b = 0; b < `COP_DATA_W/8; b++) begin
                if (req_i.w_strb[b]) mem_q[wr_idx][b*8 +: 8] <= req_i.w_data[b*8 +: 8];
            end
        end
        if (rd_fire) r_data_q <= mem_q[rd_idx];
    end

    always_comb begin
        rsp_o          = '0;
        rsp_o.aw_ready = wr_rdy_q;
        rsp_o.w_ready  = wr_rdy_q;
        rsp_o.b_valid  = b_valid_q;
        rsp_o.b_resp   = 2'b00;  // OKAY
        rsp_o.ar_ready = rd_rdy_q;
        rsp_o.r_valid  = r_valid_q;
        rsp_o.r_data   = r_data_q;
        rsp_o.r_resp   = 2'b00;
    end

endmodule

/* hw/cop_core.sv */
`timescale 1ns/10ps
`include "cop_macros.svh"

module cop_core
    import cop_isa_pkg::*, cop_bus_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   instr_valid_i,
    input  logic [31:0]            instr_i,
    input  logic [`COP_DATA_W-1:0] gpr_value_i,
    output logic                   instr_ready_o,
    output logic                   result_valid_o,
    output logic                   result_exception_o,
    output logic                   result_gpr_we_o,
    output logic [4:0]             result_rd_o,
    output logic [`COP_DATA_W-1:0] result_data_o,
    output axil_req_t              lsu_req_o,
    input  axil_rsp_t              lsu_rsp_i
);

    typedef enum logic [1:0] {ST_IDLE, ST_EXEC, ST_MEM} core_state_e;

    core_state_e            state_q;
    logic [31:0]            instr_q;
    logic [`COP_DATA_W-1:0] gpr_q;
    logic [`COP_DATA_W-1:0] xcr_q [`COP_NUM_XCR];
    cop_decoded_t           dec;
    logic [`COP_DATA_W-1:0] crs1_val, crs2_val, palu_res, lsu_rdata, wb_data;
    logic                   accept, is_mem, lsu_start, lsu_done, finish, wb_en;

    assign instr_ready_o = (state_q == ST_IDLE) && !result_valid_o;
    assign accept        = instr_valid_i && instr_ready_o;

    cop_idecode u_idecode (.encoded_i(instr_q), .decoded_o(dec));

    assign crs1_val = xcr_q[dec.crs1];
    assign crs2_val = xcr_q[dec.crs2];

    cop_palu u_palu (
        .op_i(dec.op), .pw_i(dec.pw), .a_i(crs1_val), .b_i(crs2_val),
        .shamt_i(dec.imm[5:0]), .result_o(palu_res)
    );

    assign is_mem    = dec.iclass == CLASS_LOADSTORE && !dec.exception;
    assign lsu_start = state_q == ST_EXEC && is_mem;

    cop_lsu u_lsu (
        .clk_i, .rst_n_i,
        .start_i(lsu_start), .store_i(dec.op == ST_W),
        .addr_i(gpr_q + {dec.imm[29:0], 2'b00}),  // Word offset
        .wdata_i(crs2_val),
        .done_o(lsu_done), .rdata_o(lsu_rdata),
        .req_o(lsu_req_o), .rsp_i(lsu_rsp_i)
    );

    assign finish = (state_q == ST_EXEC && !is_mem) || (state_q == ST_MEM && lsu_done);

    always_comb begin
        case (dec.op)
            GPR2XCR: wb_data = gpr_q;
            XCR2GPR: wb_data = crs1_val;
            LD_W:    wb_data = lsu_rdata;
            ST_W:    wb_data = crs2_val;  // Stored word reported back
            default: wb_data = palu_res;
        endcase
    end

    // Which cycle writes crd
    assign wb_en = !dec.exception &&
        ((state_q == ST_EXEC && (dec.iclass == CLASS_PACKED_ARITH || dec.op == GPR2XCR)) ||
         (state_q == ST_MEM && lsu_done && dec.op == LD_W));

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q        <= ST_IDLE;
            result_valid_o <= 1'b0;
            for (int i = 0; i < `COP_NUM_XCR; i++) begin
                xcr_q[i] <= '0;
            end
        end else begin
            result_valid_o <= finish;
            if (wb_en) xcr_q[dec.crd] <= wb_data;
            case (state_q)
                ST_IDLE: if (accept) state_q <= ST_EXEC;
                ST_EXEC: state_q <= is_mem ? ST_MEM : ST_IDLE;
                ST_MEM:  if (lsu_done) state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            instr_q <= instr_i;
            gpr_q   <= gpr_value_i;
        end
        if (finish) begin
            result_exception_o <= dec.exception;
            result_gpr_we_o    <= !dec.exception && dec.op == XCR2GPR;
            result_rd_o        <= dec.rd;
            result_data_o      <= dec.exception ? '0 : wb_data;
        end
    end

endmodule

/* hw/cop_top.sv */
`timescale 1ns/10ps
`include "cop_macros.svh"

module cop_top
    import cop_bus_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   instr_valid_i,
    input  logic [31:0]            instr_i,
    input  logic [`COP_DATA_W-1:0] gpr_value_i,
    output logic                   instr_ready_o,
    output logic                   result_valid_o,
    output logic                   result_exception_o,
    output logic                   result_gpr_we_o,
    output logic [4:0]             result_rd_o,
    output logic [`COP_DATA_W-1:0] result_data_o,
    input  axil_req_t              host_req_i,
    output axil_rsp_t              host_rsp_o
);

    axil_req_t lsu_req, mem_req;
    axil_rsp_t lsu_rsp, mem_rsp;

    cop_core u_core (
        .clk_i, .rst_n_i,
        .instr_valid_i, .instr_i, .gpr_value_i, .instr_ready_o,
        .result_valid_o, .result_exception_o, .result_gpr_we_o,
        .result_rd_o, .result_data_o,
        .lsu_req_o(lsu_req), .lsu_rsp_i(lsu_rsp)
    );

    // Host and LSU share the scratch memory
    cop_mem_arbiter u_arbiter (
        .clk_i, .rst_n_i,
        .host_req_i, .host_rsp_o,
        .lsu_req_i(lsu_req), .lsu_rsp_o(lsu_rsp),
        .mem_req_o(mem_req), .mem_rsp_i(mem_rsp)
    );

    cop_scratch_mem u_mem (.clk_i, .rst_n_i, .req_i(mem_req), .rsp_o(mem_rsp));

endmodule

/* tb/tb_cop_top.sv */
`timescale 1ns/10ps
`include "cop_macros.svh"

module tb_cop_top
    import cop_isa_pkg::*, cop_bus_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 100;
    localparam int MEM_IDX_W      = $clog2(`COP_MEM_WORDS);

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] gpr;
        logic        exp_exc;
        logic        exp_we;
        logic [4:0]  exp_rd;
        logic [31:0] exp_data;
    } entry_t;

    logic        clk, rst_n, instr_valid, instr_ready;
    logic [31:0] instr, gpr_value, result_data;
    logic        result_valid, result_exception, result_gpr_we;
    logic [4:0]  result_rd;
    axil_req_t   host_req;
    axil_rsp_t   host_rsp;
    integer      seed;
    entry_t      table_q [$];
    logic [31:0] xcr_model [`COP_NUM_XCR];  // Expected XCR contents
    logic [31:0] mem_model [`COP_MEM_WORDS];

    cop_top dut (
        .clk_i(clk),
        .rst_n_i(rst_n),
        .instr_valid_i(instr_valid),
        .instr_i(instr),
        .gpr_value_i(gpr_value),
        .instr_ready_o(instr_ready),
        .result_valid_o(result_valid),
        .result_exception_o(result_exception),
        .result_gpr_we_o(result_gpr_we),
        .result_rd_o(result_rd),
        .result_data_o(result_data),
        .host_req_i(host_req),
        .host_rsp_o(host_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out after %0d cycles while waiting for %s", TIMEOUT_CYCLES, what);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    function automatic logic [MEM_IDX_W-1:0] mem_index(input logic [31:0] addr);
        return addr[MEM_IDX_W+1:2];  // Upper bits wrap
    endfunction

    function automatic logic [31:0] encode(input logic [3:0] op, input logic [2:0] pw,
            input logic [5:0] imm, input logic [3:0] crd, input logic [3:0] crs1,
            input logic [3:0] crs2);
        return {op, imm, pw, crs2, crs1, crd, `COP_OPCODE_CUSTOM};
    endfunction

    // Lane by lane, each lane wraps on its own
    function automatic logic [31:0] packed_ref(input logic [3:0] op, input int w,
            input logic [31:0] a, input logic [31:0] b, input int sh);
        logic [31:0] mask, la, lb, lr, res;
        res  = '0;
        mask = (w == 32) ? 32'hffff_ffff : ((32'd1 << w) - 32'd1);
        for (int i = 0; i < 32 / w; i++) begin
            la = (a >> (i * w)) & mask;
            lb = (b >> (i * w)) & mask;
            case (op)
                PADD:    lr = la + lb;
                PSUB:    lr = la - lb;
                PSLL_I:  lr = la << sh;
                default: lr = la >> sh;
            endcase
            res = res | ((lr & mask) << (i * w));
        end
        return res;
    endfunction

    function automatic entry_t ref_exec(input logic [31:0] ins, input logic [31:0] gpr);
        entry_t      e;
        logic [3:0]  op, crd, crs1, crs2;
        logic [2:0]  pw;
        logic [5:0]  imm;
        logic [31:0] a, b, addr;
        int          w;
        e       = '0;
        e.instr = ins;
        e.gpr   = gpr;
        op      = ins[31:28];
        imm     = ins[27:22];
        pw      = ins[21:19];
        crs2    = ins[18:15];
        crs1    = ins[14:11];
        crd     = ins[10:7];
        w       = (pw == PW_16) ? 16 : ((pw == PW_8) ? 8 : 32);
        e.exp_exc = (ins[6:0] != `COP_OPCODE_CUSTOM) || (op >= 4'd8) ||
                    (op <= 4'd3 && pw > 3'd2);
        e.exp_rd  = ins[11:7];
        if (!e.exp_exc) begin
            a    = xcr_model[crs1];
            b    = xcr_model[crs2];
            addr = gpr + {24'd0, imm, 2'b00};
            case (op)
                GPR2XCR: begin
                    xcr_model[crd] = gpr;
                    e.exp_data     = gpr;
                end
                XCR2GPR: begin
                    e.exp_we   = 1'b1;
                    e.exp_data = a;
                end
                LD_W: begin
                    e.exp_data     = mem_model[mem_index(addr)];
                    xcr_model[crd] = e.exp_data;
                end
                ST_W: begin
                    mem_model[mem_index(addr)] = b;
                    e.exp_data                 = b;
                end
                default: begin
                    e.exp_data     = packed_ref(op, w, a, b, int'(imm) % w);
                    xcr_model[crd] = e.exp_data;
                end
            endcase
        end
        return e;
    endfunction

    function automatic void add_entry(input logic [31:0] ins, input logic [31:0] gpr);
        table_q.push_back(ref_exec(ins, gpr));
    endfunction

    function automatic void add_packed_group(input cop_pw_e pw);
        add_entry(encode(PADD, pw, 6'd0, 4'd5, 4'd1, 4'd2), 32'd0);
        add_entry(encode(PSUB, pw, 6'd0, 4'd6, 4'd2, 4'd4), 32'd0);
        add_entry(encode(PADD, pw, 6'd0, 4'd7, 4'd4, 4'd4), 32'd0);  // Carry out of each lane
        add_entry(encode(PSLL_I, pw, 6'd13, 4'd8, 4'd3, 4'd0), 32'd0);
        add_entry(encode(PSRL_I, pw, 6'd37, 4'd9, 4'd3, 4'd0), 32'd0);
    endfunction

    task automatic host_write(input logic [31:0] addr, input logic [31:0] data);
        int n;
        host_req.aw_valid = 1'b1;
        host_req.aw_addr  = addr;
        host_req.w_valid  = 1'b1;
        host_req.w_data   = data;
        host_req.w_strb   = 4'hf;
        host_req.b_ready  = 1'b1;
        n = 0;
        while (!(host_rsp.aw_ready && host_rsp.w_ready)) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT_CYCLES) report_timeout("host write address");
        end
        @(posedge clk);
        #1;
        host_req.aw_valid = 1'b0;
        host_req.w_valid  = 1'b0;
        n = 0;
        while (!host_rsp.b_valid) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT_CYCLES) report_timeout("host write response");
        end
        check_equal(32'(host_rsp.b_resp), 32'd0, "host write response code");
        @(posedge clk);
        #1;
        host_req.b_ready = 1'b0;
        mem_model[mem_index(addr)] = data;  // Mirror in the model
    endtask

    task automatic host_read(input logic [31:0] addr, output logic [31:0] data);
        int n;
        host_req.ar_valid = 1'b1;
        host_req.ar_addr  = addr;
        host_req.r_ready  = 1'b1;
        n = 0;
        while (!host_rsp.ar_ready) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT_CYCLES) report_timeout("host read address");
        end
        @(posedge clk);
        #1;
        host_req.ar_valid = 1'b0;
        n = 0;
        while (!host_rsp.r_valid) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT_CYCLES) report_timeout("host read data");
        end
        data = host_rsp.r_data;
        check_equal(32'(host_rsp.r_resp), 32'd0, "host read response code");
        @(posedge clk);
        #1;
        host_req.r_ready = 1'b0;
    endtask

    task automatic run_instruction(input entry_t e, input int idx);
        int n;
        n = 0;
        while (!instr_ready) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT_CYCLES) report_timeout("instruction ready");
        end
        instr_valid = 1'b1;
        instr       = e.instr;
        gpr_value   = e.gpr;
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        n = 0;
        while (!result_valid) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT_CYCLES) report_timeout("instruction completion");
        end
        check_equal(32'(result_exception), 32'(e.exp_exc), $sformatf("entry %0d exception", idx));
        check_equal(32'(result_gpr_we), 32'(e.exp_we), $sformatf("entry %0d gpr_we", idx));
        if (!e.exp_exc) check_equal(result_data, e.exp_data, $sformatf("entry %0d data", idx));
        if (e.exp_we) check_equal(32'(result_rd), 32'(e.exp_rd), $sformatf("entry %0d rd", idx));
    endtask

    initial begin
        logic [31:0] v;
        logic [31:0] rdata;
        seed        = 46913;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        gpr_value   = '0;
        host_req    = '0;
        xcr_model   = '{default: '0};
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        v = $random(seed);
        host_write(32'h0000_0040, v);
        host_read(32'h0000_0040, rdata);
        check_equal(rdata, v, "host read after host write");
        v = $random(seed);
        host_write(32'h0000_010c, v);  // Source word for LD_W

        for (int i = 1; i <= 3; i++) begin
            v = $random(seed);
            add_entry(encode(GPR2XCR, PW_32, 6'd0, 4'(i), 4'd0, 4'd0), v);
        end
        add_entry(encode(GPR2XCR, PW_32, 6'd0, 4'd4, 4'd0, 4'd0), 32'h80ff_7fff);
        add_entry(encode(XCR2GPR, PW_32, 6'd0, 4'd5, 4'd1, 4'd0), 32'd0);  // rd 21
        add_packed_group(PW_32);
        add_packed_group(PW_16);
        add_packed_group(PW_8);
        add_entry(encode(ST_W, PW_32, 6'd5, 4'd0, 4'd0, 4'd1), 32'h0000_0200);
        add_entry(encode(ST_W, PW_32, 6'd63, 4'd0, 4'd0, 4'd5), 32'h0000_0300);
        add_entry(encode(LD_W, PW_32, 6'd3, 4'd10, 4'd0, 4'd0), 32'h0000_0100);
        add_entry(encode(LD_W, PW_32, 6'd1, 4'd11, 4'd0, 4'd0), 32'h0000_0210);
        add_entry(encode(XCR2GPR, PW_32, 6'd0, 4'd2, 4'd10, 4'd0), 32'd0);

        // Faulting instructions all aim at x1
        v = $random(seed);
        add_entry(encode(GPR2XCR, PW_32, 6'd0, 4'd1, 4'd0, 4'd0) ^ 32'h0000_0040, v);
        add_entry(encode(4'd9, PW_32, 6'd0, 4'd1, 4'd2, 4'd3), v);
        add_entry(encode(PADD, 3'b011, 6'd0, 4'd1, 4'd2, 4'd3), 32'd0);
        add_entry(encode(PSUB, 3'b100, 6'd0, 4'd1, 4'd2, 4'd3), 32'd0);
        add_entry(encode(PSLL_I, 3'b111, 6'd4, 4'd1, 4'd2, 4'd0), 32'd0);
        add_entry(encode(XCR2GPR, PW_32, 6'd0, 4'd3, 4'd1, 4'd0), 32'd0);

        for (int i = 0; i < table_q.size(); i++) begin
            run_instruction(table_q[i], i);
        end

        host_read(32'h0000_0214, rdata);
        check_equal(rdata, mem_model[mem_index(32'h0000_0214)], "host read of ST_W word");
        host_read(32'h0000_03fc, rdata);
        check_equal(rdata, mem_model[mem_index(32'h0000_03fc)], "host read of top word");

        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* cop.f */
+incdir+hw
hw/cop_isa_pkg.sv
hw/cop_bus_pkg.sv
hw/cop_idecode.sv
hw/cop_palu.sv
hw/cop_lsu.sv
hw/cop_mem_arbiter.sv
hw/cop_scratch_mem.sv
hw/cop_core.sv
hw/cop_top.sv
tb/tb_cop_top.sv

/* run_sim.sh */
#!/bin/sh
# Build the coprocessor testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f cop.f --top-module tb_cop_top \
    && ./obj_dir/Vtb_cop_top > sim.log 2>&1 \
    || echo "Build or simulation stopped with an error" >> sim.log
cat sim.log
grep -qx "STATUS: PASS" sim.log && exit 0 || exit 1
